/* run_sim.sh */
#!/bin/sh
# build and run the host_io testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 \
	-f sim.f --top-module host_io_tb -o Vhost_io_tb

status=0
./obj_dir/Vhost_io_tb +verilator+error+limit+10 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation failed" sim.log || [ "$status" -ne 0 ]; then
	echo "RESULT: FAIL"
	exit 1
fi
echo "RESULT: PASS"

/* sim.f */
+incdir+source
source/host_io_pkg.sv
source/uio_link.sv
source/ctrl_regs.sv
source/ps2_key_decoder.sv
source/file_download.sv
source/host_io.sv
tests/tb_clk_gen.sv
tests/host_io_chk.sv
tests/host_io_tb.sv

/* source/ctrl_regs.sv */
//////////////////////////////////////////////////
// core-side registers written by uio commands:
// config, joysticks and status. Also tracks the
// core's status-set requests and answers reads
//////////////////////////////////////////////////
`include "host_io_defs.svh"

module ctrl_regs
	import host_io_pkg::*;
(
	input  logic     clk_sys,
	input  logic     rst_n,
	input  io_beat_t beat,
	input  status_t  status_in,
	input  logic     status_set,
	output cfg_t     cfg,
	output joy_t     joystick_0,
	output joy_t     joystick_1,
	output status_t  status,
	output io_word_t io_dout
);

	logic       set_q;
	logic       set_rise;
	logic [3:0] req_cnt;
	status_t    status_req;
	logic [2:0] slot;
	logic       slot_ok;
	io_word_t   req_word;

	assign set_rise = status_set && !set_q;

	// word 1 maps to slot 0, status is sent lowest word first
	assign slot     = 3'(beat.idx - 6'd1);
	assign slot_ok  = (beat.idx != '0) &&
	                  (beat.idx <= word_idx_t'(`HIO_STATUS_WORDS));
	assign req_word = status_req[{slot, 4'b0000} +: 16];

	//////////////////////////////////////////////////
	// status-set capture
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (set_rise) begin
			status_req <= status_in;
		end
	end

	//////////////////////////////////////////////////
	// command decode
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			set_q      <= 1'b0;
			req_cnt    <= '0;
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
			io_dout    <= '0;
		end else begin
			set_q <= status_set;
			if (set_rise) begin
				req_cnt <= req_cnt + 4'd1;
			end

			if (beat.valid) begin
				// nothing to read unless a command below answers
				io_dout <= '0;
				if (beat.first) begin
					if (beat.cmd == `HIO_CMD_STATUS_REQ) begin
						io_dout <= {8'h00, `HIO_REQ_TAG, req_cnt};
					end
				end else begin
					case (beat.cmd)
						`HIO_CMD_CFG: begin
							cfg <= beat.data;
						end
						`HIO_CMD_JOY0: begin
							if (beat.idx == 6'd1) begin
								joystick_0[15:0] <= beat.data;
							end else begin
								joystick_0[31:16] <= beat.data;
							end
						end
						`HIO_CMD_JOY1: begin
							if (beat.idx == 6'd1) begin
								joystick_1[15:0] <= beat.data;
							end else begin
								joystick_1[31:16] <= beat.data;
							end
						end
						`HIO_CMD_STATUS: begin
							if (slot_ok) begin
								status[{slot, 4'b0000} +: 16] <= beat.data;
							end
						end
						`HIO_CMD_STATUS_REQ: begin
							if (slot_ok) begin
								io_dout <= req_word;
							end
						end
						default: begin
						end
					endcase
				end
			end
		end
	end

endmodule

/* source/file_download.sv */
//////////////////////////////////////////////////
// file path of the bridge. Decodes file frames
// into the download index, file extension and
// byte write pulses with a running address
//////////////////////////////////////////////////
`include "host_io_defs.svh"

module file_download
	import host_io_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        fp_enable,
	input  logic        io_strobe,
	input  io_word_t    io_din,
	output logic        ioctl_download,
	output logic        ioctl_wr,
	output io_word_t    ioctl_index,
	output logic [31:0] ioctl_file_ext,
	output ioctl_addr_t ioctl_addr,
	output logic [7:0]  ioctl_dout
);

	io_cmd_t     cmd_q;
	logic        has_cmd;
	logic [1:0]  arg_cnt;
	logic        wr_q;
	ioctl_addr_t addr;
	logic        arg_stb;
	logic        is_tx;
	logic        tx_start;
	logic        tx_stop;
	logic        dat_wr;

	// every strobe after the opcode is an argument word
	assign arg_stb  = fp_enable && io_strobe && has_cmd;
	assign is_tx    = arg_stb && (cmd_q == `HIO_FIO_TX) && (arg_cnt == 2'd0);
	assign tx_start = is_tx && (io_din[7:0] != 8'h00);
	assign tx_stop  = is_tx && (io_din[7:0] == 8'h00);
	assign dat_wr   = arg_stb && (cmd_q == `HIO_FIO_TX_DAT) && ioctl_download;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cmd_q          <= '0;
			has_cmd        <= 1'b0;
			arg_cnt        <= '0;
			wr_q           <= 1'b0;
			ioctl_wr       <= 1'b0;
			ioctl_download <= 1'b0;
		end else begin
			// write pulse lands one cycle after the data is presented
			ioctl_wr <= wr_q;
			wr_q     <= dat_wr;
			if (!fp_enable) begin
				has_cmd <= 1'b0;
			end else if (io_strobe && !has_cmd) begin
				cmd_q   <= io_din;
				has_cmd <= 1'b1;
				arg_cnt <= '0;
			end else if (arg_stb && !(&arg_cnt)) begin
				arg_cnt <= arg_cnt + 2'd1;
			end
			if (tx_start) begin
				ioctl_download <= 1'b1;
			end else if (tx_stop) begin
				ioctl_download <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// index, extension and address datapath
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (arg_stb) begin
			if (cmd_q == `HIO_FIO_INDEX) begin
				ioctl_index <= io_din;
			end
			if ((cmd_q == `HIO_FIO_INFO) && (arg_cnt == 2'd0)) begin
				ioctl_file_ext[31:16] <= io_din;
			end
			if ((cmd_q == `HIO_FIO_INFO) && (arg_cnt == 2'd1)) begin
				ioctl_file_ext[15:0] <= io_din;
			end
			if ((cmd_q == `HIO_FIO_TX) && (arg_cnt == 2'd1)) begin
				ioctl_addr[15:0] <= io_din;
				addr[15:0]       <= io_din;
			end
			if ((cmd_q == `HIO_FIO_TX) && (arg_cnt == 2'd2)) begin
				ioctl_addr[26:16] <= io_din[10:0];
				addr[26:16]       <= io_din[10:0];
			end
		end
		if (tx_start) begin
			addr <= '0;
		end
		// stop presents the address after the last byte
		if (tx_stop && ioctl_download) begin
			ioctl_addr <= addr;
		end
		if (dat_wr) begin
			ioctl_addr <= addr;
			ioctl_dout <= io_din[7:0];
			addr       <= addr + 1'b1;
		end
	end

endmodule

/* source/host_io.sv */
//////////////////////////////////////////////////
// host I/O bridge top. Connects the uio framing,
// the register block, the keyboard decoder and
// the file download path to the core
//////////////////////////////////////////////////
`include "host_io_defs.svh"

module host_io
	import host_io_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        io_strobe,
	input  logic        io_enable,
	input  logic        fp_enable,
	input  io_word_t    io_din,
	input  status_t     status_in,
	input  logic        status_set,
	output io_word_t    io_dout,
	output logic [1:0]  buttons,
	output logic        forced_scandoubler,
	output logic        direct_video,
	output joy_t        joystick_0,
	output joy_t        joystick_1,
	output status_t     status,
	output ps2_key_t    ps2_key,
	output logic        ioctl_download,
	output logic        ioctl_wr,
	output io_word_t    ioctl_index,
	output logic [31:0] ioctl_file_ext,
	output ioctl_addr_t ioctl_addr,
	output logic [7:0]  ioctl_dout
);

	io_beat_t      beat;
	io_frame_end_t frame_end;
	cfg_t          cfg;

	assign buttons            = cfg[`HIO_CFG_BUTTONS_BIT +: 2];
	assign forced_scandoubler = cfg[`HIO_CFG_SCANDBL_BIT];
	assign direct_video       = cfg[`HIO_CFG_DIRECT_BIT];

	uio_link u_link (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.io_strobe (io_strobe),
		.io_enable (io_enable),
		.io_din    (io_din),
		.beat      (beat),
		.frame_end (frame_end)
	);

	ctrl_regs u_regs (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.beat       (beat),
		.status_in  (status_in),
		.status_set (status_set),
		.cfg        (cfg),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.status     (status),
		.io_dout    (io_dout)
	);

	ps2_key_decoder u_kbd (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.beat      (beat),
		.frame_end (frame_end),
		.ps2_key   (ps2_key)
	);

	// file frames are bracketed by fp_enable, not io_enable
	file_download u_dl (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.fp_enable      (fp_enable),
		.io_strobe      (io_strobe),
		.io_din         (io_din),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

endmodule

/* source/host_io_defs.svh */
//////////////////////////////////////////////////
// command codes, file-path opcodes and field
// positions of the host I/O bridge. Include
// wherever a code or a width is compared
//////////////////////////////////////////////////
`ifndef HOST_IO_DEFS_SVH
`define HOST_IO_DEFS_SVH

// bus and field widths
`define HIO_WORD_W          16
`define HIO_IDX_W           6
`define HIO_ADDR_W          27

// uio command codes, compared against the 16-bit word 0
`define HIO_CMD_CFG         16'h0001
`define HIO_CMD_JOY0        16'h0002
`define HIO_CMD_JOY1        16'h0003
`define HIO_CMD_KBD         16'h0005
`define HIO_CMD_STATUS      16'h001E
`define HIO_CMD_STATUS_REQ  16'h0029

// file-path opcodes
`define HIO_FIO_TX          16'h0053
`define HIO_FIO_TX_DAT      16'h0054
`define HIO_FIO_INDEX       16'h0055
`define HIO_FIO_INFO        16'h0056

`define HIO_STATUS_WORDS    8
`define HIO_REQ_TAG         4'hA
`define HIO_KBD_SKIP_MARK   8'hFF

// config word layout
`define HIO_CFG_BUTTONS_BIT 0
`define HIO_CFG_SCANDBL_BIT 4
`define HIO_CFG_DIRECT_BIT  10

`endif

/* source/host_io_pkg.sv */
//////////////////////////////////////////////////
// shared types of the host I/O bridge: bus words,
// core-side registers and the framed bus events
// passed from the link to its consumers
//////////////////////////////////////////////////
`include "host_io_defs.svh"

package host_io_pkg;

	typedef logic [`HIO_WORD_W-1:0] io_word_t;
	typedef logic [`HIO_WORD_W-1:0] io_cmd_t;
	typedef logic [`HIO_IDX_W-1:0]  word_idx_t;

	typedef logic [31:0]             joy_t;
	typedef logic [127:0]            status_t;
	typedef logic [`HIO_WORD_W-1:0] cfg_t;
	typedef logic [`HIO_ADDR_W-1:0] ioctl_addr_t;

	// [10] toggle, [9] pressed, [8] extended, [7:0] code
	typedef logic [10:0]             ps2_key_t;

	// one word of a uio frame, valid for a single cycle
	typedef struct packed {
		io_cmd_t   cmd;
		word_idx_t idx;
		io_word_t  data;
		logic      first;
		logic      valid;
	} io_beat_t;

	// end of a uio frame, carries the command it closed
	typedef struct packed {
		logic    pulse;
		io_cmd_t cmd;
	} io_frame_end_t;

endpackage

/* source/ps2_key_decoder.sv */
//////////////////////////////////////////////////
// keyboard event path. Collects the scan bytes of
// a keyboard frame and turns them into one key
// event word when the frame closes
//////////////////////////////////////////////////
`include "host_io_defs.svh"

module ps2_key_decoder
	import host_io_pkg::*;
(
	input  logic          clk_sys,
	input  logic          rst_n,
	input  io_beat_t      beat,
	input  io_frame_end_t frame_end,
	output ps2_key_t      ps2_key
);

	// multi-byte sequences with a fixed event code
	localparam logic [31:0] seq_prnscr_press   = 32'hE012_E07C;
	localparam logic [31:0] seq_prnscr_release = 32'h7CE0_F012;
	localparam logic [31:0] seq_pause_press    = 32'hF014_F077;

	logic [31:0] kbd_raw;
	logic        skip;
	logic        kbd_beat;
	logic        pressed;
	logic        extended;
	logic [9:0]  key_low;

	assign kbd_beat = beat.valid && (beat.cmd == `HIO_CMD_KBD);
	assign pressed  = (kbd_raw[15:8] != 8'hF0);
	assign extended = pressed ? (kbd_raw[15:8] == 8'hE0) : (kbd_raw[23:16] == 8'hE0);

	always_comb begin
		key_low = {pressed, extended, kbd_raw[7:0]};
		case (kbd_raw)
			seq_prnscr_press:   key_low = 10'h37C;
			seq_prnscr_release: key_low = 10'h17C;
			seq_pause_press:    key_low = 10'h377;
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			kbd_raw <= '0;
			skip    <= 1'b0;
			ps2_key <= '0;
		end else begin
			if (kbd_beat) begin
				if (beat.first) begin
					kbd_raw <= '0;
					skip    <= 1'b0;
				end else if (beat.data[15:8] == `HIO_KBD_SKIP_MARK) begin
					skip <= 1'b1;
				end else if (!skip) begin
					kbd_raw <= {kbd_raw[23:0], beat.data[7:0]};
				end
			end

			if (frame_end.pulse) begin
				skip <= 1'b0;
				if ((frame_end.cmd == `HIO_CMD_KBD) && !skip) begin
					ps2_key <= {~ps2_key[10], key_low};
				end
			end
		end
	end

endmodule

/* source/uio_link.sv */
//////////////////////////////////////////////////
// frames the strobed host bus into beats.
// word 0 of a frame is the command, later words
// carry their index. knows no command codes
//////////////////////////////////////////////////

module uio_link
	import host_io_pkg::*;
(
	input  logic          clk_sys,
	input  logic          rst_n,
	input  logic          io_strobe,
	input  logic          io_enable,
	input  io_word_t      io_din,
	output io_beat_t      beat,
	output io_frame_end_t frame_end
);

	word_idx_t word_cnt;
	io_cmd_t   cmd_q;
	logic      frame_act;
	logic      word0;

	assign word0 = (word_cnt == '0);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			word_cnt  <= '0;
			cmd_q     <= '0;
			frame_act <= 1'b0;
			beat      <= '0;
			frame_end <= '0;
		end else begin
			beat.valid      <= 1'b0;
			frame_end.pulse <= 1'b0;

			if (!io_enable) begin
				word_cnt <= '0;
				// close the frame once, on the first idle cycle
				if (frame_act) begin
					frame_end.pulse <= 1'b1;
					frame_end.cmd   <= cmd_q;
					frame_act       <= 1'b0;
				end
			end else begin
				frame_act <= 1'b1;
				if (io_strobe) begin
					beat.valid <= 1'b1;
					beat.first <= word0;
					beat.idx   <= word_cnt;
					beat.data  <= io_din;
					beat.cmd   <= word0 ? io_din : cmd_q;
					if (word0) begin
						cmd_q <= io_din;
					end
					// saturate, long frames keep the last index
					if (!(&word_cnt)) begin
						word_cnt <= word_cnt + 1'b1;
					end
				end
			end
		end
	end

endmodule

/* tests/host_io_chk.sv */
//////////////////////////////////////////////////
// protocol assertions of the host I/O bridge,
// bound onto every host_io instance
//////////////////////////////////////////////////

module host_io_chk (
	input logic clk_sys,
	input logic rst_n,
	input logic io_enable,
	input logic beat_valid,
	input logic ioctl_wr,
	input logic ioctl_download
);

	timeunit 1ns;
	timeprecision 1ps;

	// set by any failing assertion, watched by the testbench
	logic failed = 1'b0;

	// one write pulse per data word
	wr_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl_wr |=> !ioctl_wr)
		else begin
			$error("ioctl_wr high on two cycles in a row");
			failed = 1'b1;
		end

	wr_in_download: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl_wr |-> ioctl_download)
		else begin
			$error("ioctl_wr high while no download is active");
			failed = 1'b1;
		end

	// beats only come from inside a uio frame
	beat_in_frame: assert property (@(posedge clk_sys) disable iff (!rst_n)
		beat_valid |-> io_enable)
		else begin
			$error("beat.valid high outside io_enable");
			failed = 1'b1;
		end

endmodule

bind host_io host_io_chk u_chk (
	.clk_sys        (clk_sys),
	.rst_n          (rst_n),
	.io_enable      (io_enable),
	.beat_valid     (beat.valid),
	.ioctl_wr       (ioctl_wr),
	.ioctl_download (ioctl_download)
);

/* tests/host_io_tb.sv */
//////////////////////////////////////////////////
// directed testbench of the host I/O bridge.
// drives uio and file frames on the falling edge
// and checks registers, key events and downloads
//////////////////////////////////////////////////
`include "host_io_defs.svh"

module host_io_tb
	import host_io_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	logic        clk_sys;
	logic        rst_n;
	logic        io_strobe;
	logic        io_enable;
	logic        fp_enable;
	io_word_t    io_din;
	status_t     status_in;
	logic        status_set;
	io_word_t    io_dout;
	logic [1:0]  buttons;
	logic        forced_scandoubler;
	logic        direct_video;
	joy_t        joystick_0;
	joy_t        joystick_1;
	status_t     status;
	ps2_key_t    ps2_key;
	logic        ioctl_download;
	logic        ioctl_wr;
	io_word_t    ioctl_index;
	logic [31:0] ioctl_file_ext;
	ioctl_addr_t ioctl_addr;
	logic [7:0]  ioctl_dout;

	// words of the frame to send, and io_dout seen at each of its strobes
	io_word_t    tx_q[$];
	io_word_t    rx_q[$];
	// every ioctl_wr pulse in order
	ioctl_addr_t wr_addr_q[$];
	logic [7:0]  wr_data_q[$];

	tb_clk_gen u_clk (
		.clk_sys (clk_sys),
		.rst_n   (rst_n)
	);

	host_io dut (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.io_strobe          (io_strobe),
		.io_enable          (io_enable),
		.fp_enable          (fp_enable),
		.io_din             (io_din),
		.status_in          (status_in),
		.status_set         (status_set),
		.io_dout            (io_dout),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.ps2_key            (ps2_key),
		.ioctl_download     (ioctl_download),
		.ioctl_wr           (ioctl_wr),
		.ioctl_index        (ioctl_index),
		.ioctl_file_ext     (ioctl_file_ext),
		.ioctl_addr         (ioctl_addr),
		.ioctl_dout         (ioctl_dout)
	);

	//////////////////////////////////////////////////
	// reporting and typed compares
	//////////////////////////////////////////////////

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic report_mismatch(input string what, input string exp, input string got);
		abort_run($sformatf("Mismatch at %0t ns: %s, expected %s, got %s",
			$time, what, exp, got));
	endtask

	task automatic word_matches(input string what, input io_word_t got, input io_word_t exp);
		if (got !== exp) begin
			report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", got));
		end
	endtask

	task automatic joy_matches(input string what, input joy_t got, input joy_t exp);
		if (got !== exp) begin
			report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", got));
		end
	endtask

	task automatic status_matches(input string what, input status_t got, input status_t exp);
		if (got !== exp) begin
			report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", got));
		end
	endtask

	task automatic key_matches(input string what, input ps2_key_t got, input ps2_key_t exp);
		if (got !== exp) begin
			report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", got));
		end
	endtask

	task automatic addr_matches(input string what, input ioctl_addr_t got,
			input ioctl_addr_t exp);
		if (got !== exp) begin
			report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", got));
		end
	endtask

	task automatic byte_matches(input string what, input logic [7:0] got,
			input logic [7:0] exp);
		if (got !== exp) begin
			report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", got));
		end
	endtask

	task automatic flag_matches(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			report_mismatch(what, $sformatf("%b", exp), $sformatf("%b", got));
		end
	endtask

	// the three core outputs cut from the config word
	task automatic cfg_bits_match(input cfg_t exp);
		logic [3:0] want;
		logic [3:0] seen;
		want = {exp[`HIO_CFG_BUTTONS_BIT +: 2], exp[`HIO_CFG_SCANDBL_BIT],
			exp[`HIO_CFG_DIRECT_BIT]};
		seen = {buttons, forced_scandoubler, direct_video};
		if (seen !== want) begin
			report_mismatch("buttons, scandoubler, direct_video",
				$sformatf("%b", want), $sformatf("%b", seen));
		end
	endtask

	//////////////////////////////////////////////////
	// bus driver and waits
	//////////////////////////////////////////////////

	// capture write pulses and watch the bound checker
	always @(negedge clk_sys) begin
		if (ioctl_wr === 1'b1) begin
			wr_addr_q.push_back(ioctl_addr);
			wr_data_q.push_back(ioctl_dout);
		end
		if (dut.u_chk.failed === 1'b1) begin
			abort_run("an assertion in host_io_chk failed");
		end
	end

	task automatic wait_reset();
		int n;
		n = 0;
		while (rst_n !== 1'b1) begin
			if (n == 20) begin
				abort_run("reset was never released");
			end
			n++;
			@(negedge clk_sys);
		end
	endtask

	// called on a falling edge, io_dout is sampled as the strobe goes up
	task automatic send_word(input io_word_t w, output io_word_t rd);
		rd = io_dout;
		io_strobe = 1'b1;
		io_din = w;
		@(negedge clk_sys);
		io_strobe = 1'b0;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic send_frame(input logic file_path);
		io_word_t rd;
		rx_q.delete();
		if (file_path) begin
			fp_enable = 1'b1;
		end else begin
			io_enable = 1'b1;
		end
		foreach (tx_q[i]) begin
			send_word(tx_q[i], rd);
			rx_q.push_back(rd);
		end
		io_enable = 1'b0;
		fp_enable = 1'b0;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic wait_key_change(input ps2_key_t prev);
		int n;
		n = 0;
		while (ps2_key[10] === prev[10]) begin
			if (n == 16) begin
				abort_run("no key event after a keyboard frame");
			end
			n++;
			@(negedge clk_sys);
		end
	endtask

	task automatic wait_writes(input int count);
		int n;
		n = 0;
		while (wr_addr_q.size() < count) begin
			if (n == 32) begin
				abort_run("too few ioctl_wr pulses for the data words");
			end
			n++;
			@(negedge clk_sys);
		end
	endtask

	function automatic status_t rand_status();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic reset_values_test();
		word_matches("io_dout after reset", io_dout, '0);
		key_matches("ps2_key after reset", ps2_key, '0);
		status_matches("status after reset", status, '0);
		cfg_bits_match('0);
		flag_matches("ioctl_download after reset", ioctl_download, 1'b0);
		flag_matches("ioctl_wr after reset", ioctl_wr, 1'b0);
	endtask

	task automatic cfg_joy_test();
		cfg_t     c;
		joy_t     j0;
		joy_t     j1;
		io_word_t lo;
		c = cfg_t'($urandom);
		tx_q = '{`HIO_CMD_CFG, c};
		send_frame(1'b0);
		cfg_bits_match(c);
		j0 = $urandom;
		j1 = $urandom;
		tx_q = '{`HIO_CMD_JOY0, j0[15:0], j0[31:16]};
		send_frame(1'b0);
		tx_q = '{`HIO_CMD_JOY1, j1[15:0], j1[31:16]};
		send_frame(1'b0);
		joy_matches("joystick_0", joystick_0, j0);
		joy_matches("joystick_1", joystick_1, j1);
		// a frame with word 1 only keeps the high half
		lo = io_word_t'($urandom);
		tx_q = '{`HIO_CMD_JOY0, lo};
		send_frame(1'b0);
		joy_matches("joystick_0 low half only", joystick_0, {j0[31:16], lo});
	endtask

	task automatic status_test();
		status_t  exp;
		io_word_t w;
		tx_q = '{`HIO_CMD_STATUS};
		for (int i = 0; i < `HIO_STATUS_WORDS; i++) begin
			w = io_word_t'($urandom);
			tx_q.push_back(w);
			exp[i*16 +: 16] = w;
		end
		send_frame(1'b0);
		status_matches("status", status, exp);
	endtask

	task automatic status_req_test();
		status_t cap;
		int      n;
		n = 1 + int'($urandom % 30);
		for (int i = 0; i < n; i++) begin
			cap = rand_status();
			status_in = cap;
			status_set = 1'b1;
			@(negedge clk_sys);
			status_set = 1'b0;
			@(negedge clk_sys);
		end
		// command, eight reads and one more strobe to sample the last answer
		tx_q = '{`HIO_CMD_STATUS_REQ};
		for (int i = 0; i < `HIO_STATUS_WORDS + 1; i++) begin
			tx_q.push_back('0);
		end
		send_frame(1'b0);
		word_matches("status request tag", rx_q[1], {8'h00, `HIO_REQ_TAG, n[3:0]});
		for (int i = 0; i < `HIO_STATUS_WORDS; i++) begin
			word_matches($sformatf("captured status word %0d", i), rx_q[i+2],
				cap[i*16 +: 16]);
		end
		word_matches("io_dout past the last word", io_dout, '0);
	endtask

	// bytes of seq are sent oldest first, exp is {pressed, extended, code}
	task automatic key_event(input string what, input logic [63:0] seq, input int len,
			input logic [9:0] exp);
		ps2_key_t prev;
		prev = ps2_key;
		tx_q = '{`HIO_CMD_KBD};
		for (int i = len - 1; i >= 0; i--) begin
			tx_q.push_back({8'h00, seq[i*8 +: 8]});
		end
		send_frame(1'b0);
		wait_key_change(prev);
		key_matches(what, ps2_key, {~prev[10], exp});
	endtask

	task automatic keyboard_test();
		logic [7:0] code;
		ps2_key_t   prev;
		code = 8'(1 + $urandom % 127);
		key_event("random plain press", {56'h0, code}, 1, {2'b10, code});
		key_event("plain press", 64'h1C, 1, 10'h21C);
		key_event("plain release", 64'hF01C, 2, 10'h01C);
		key_event("extended press", 64'hE075, 2, 10'h375);
		key_event("extended release", 64'hE0F075, 3, 10'h175);
		key_event("print screen press", 64'hE012E07C, 4, 10'h37C);
		key_event("print screen release", 64'hE0F07CE0F012, 6, 10'h17C);
		key_event("pause press", 64'hE11477E1F014F077, 8, 10'h377);
		// the skip mark drops the whole frame
		prev = ps2_key;
		tx_q = '{`HIO_CMD_KBD, 16'h001C, {`HIO_KBD_SKIP_MARK, 8'h00}};
		send_frame(1'b0);
		repeat (4) @(negedge clk_sys);
		key_matches("skipped keyboard frame", ps2_key, prev);
		key_event("press after a skipped frame", 64'h2B, 1, 10'h22B);
	endtask

	task automatic download_test();
		io_word_t    idx;
		logic [31:0] ext;
		ioctl_addr_t base;
		logic [7:0]  data[$];
		int          n;
		idx = io_word_t'($urandom);
		tx_q = '{`HIO_FIO_INDEX, idx};
		send_frame(1'b1);
		word_matches("ioctl_index", ioctl_index, idx);
		ext = $urandom;
		tx_q = '{`HIO_FIO_INFO, ext[31:16], ext[15:0]};
		send_frame(1'b1);
		word_matches("file extension high", ioctl_file_ext[31:16], ext[31:16]);
		word_matches("file extension low", ioctl_file_ext[15:0], ext[15:0]);
		base = ioctl_addr_t'($urandom);
		tx_q = '{`HIO_FIO_TX, 16'h00FF, base[15:0], {5'b0, base[26:16]}};
		send_frame(1'b1);
		flag_matches("ioctl_download after start", ioctl_download, 1'b1);
		n = 4 + int'($urandom % 8);
		wr_addr_q.delete();
		wr_data_q.delete();
		tx_q = '{`HIO_FIO_TX_DAT};
		for (int i = 0; i < n; i++) begin
			data.push_back(8'($urandom));
			// the high byte is ignored by the byte path
			tx_q.push_back({8'($urandom), data[i]});
		end
		send_frame(1'b1);
		wait_writes(n);
		if (wr_addr_q.size() != n) begin
			abort_run($sformatf("%0d write pulses for %0d data words", wr_addr_q.size(), n));
		end
		for (int i = 0; i < n; i++) begin
			addr_matches($sformatf("write %0d address", i), wr_addr_q[i],
				ioctl_addr_t'(base + i));
			byte_matches($sformatf("write %0d data", i), wr_data_q[i], data[i]);
		end
		tx_q = '{`HIO_FIO_TX, 16'h0000};
		send_frame(1'b1);
		flag_matches("ioctl_download after stop", ioctl_download, 1'b0);
		addr_matches("ioctl_addr after stop", ioctl_addr, ioctl_addr_t'(base + n));
	endtask

	initial begin
		io_strobe  = 1'b0;
		io_enable  = 1'b0;
		fp_enable  = 1'b0;
		status_set = 1'b0;
		io_din     = '0;
		status_in  = '0;
		void'($urandom(32'h21bc1a0f));
		wait_reset();
		reset_values_test();
		cfg_joy_test();
		status_test();
		status_req_test();
		keyboard_test();
		download_test();
		if (dut.u_chk.failed === 1'b1) begin
			abort_run("an assertion in host_io_chk failed");
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

/* tests/tb_clk_gen.sv */
//////////////////////////////////////////////////
// testbench clock and reset. clk_sys runs with a
// 4 ns period, rst_n is held low for 4 cycles
//////////////////////////////////////////////////

module tb_clk_gen (
	output logic clk_sys,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// release on a falling edge, away from the flops
	initial begin
		rst_n = 1'b0;
		repeat (4) @(negedge clk_sys);
		rst_n = 1'b1;
	end

endmodule
